//--- compile.f
+incdir+verilog
verilog/pal_bars_pkg.sv
verilog/raster_if.sv
verilog/raster_counter.sv
verilog/sync_decoder.sv
verilog/color_bars.sv
verilog/pal_bars_top.sv
dv/pal_bars_chk.sv
dv/pal_bars_tb.sv

//--- run.sh
#!/bin/sh
# build and run the PAL colour bar testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module pal_bars_tb -f compile.f -o sim_pal_bars \
   && ./obj_dir/sim_pal_bars > sim.log 2>&1 \
   || echo "build or simulation returned an error status" >> sim.log
cat sim.log
grep -q "sim passed" sim.log && ! grep -q "sim failed" sim.log && exit 0 || exit 1

//--- dv/pal_bars_tb.sv
`timescale 1ns/1ps
`include "pal_bars_settings.svh"

module pal_bars_tb
   import pal_bars_pkg::*;
;

   localparam int max_cycles = (2 * `PB_V_TOTAL_INT + 3 * `PB_V_TOTAL_PROG + 8) * `PB_H_TOTAL;
   localparam int random_cycles = 3 * `PB_V_TOTAL_PROG * `PB_H_TOTAL;
   localparam logic [23:0] bar_table = {3'b111, 3'b110, 3'b011, 3'b010,
                                        3'b101, 3'b100, 3'b001, 3'b000};

   logic       clk;
   logic       rst_n;
   logic       mode;
   logic [2:0] r;
   logic [2:0] g;
   logic [2:0] b;
   logic       csync;

   logic [9:0]  m_hc;
   logic [9:0]  m_vc;
   logic [9:0]  exp_hc;
   logic [9:0]  exp_vc;
   logic        m_prog;
   logic        exp_csync;
   logic        checking;
   rgb_t        exp_rgb;
   logic [31:0] lfsr_state = 32'h1fb35c32;
   int          err_model = 0;
   int          err_direct = 0;
   int          tests_failed = 0;
   int          cycle_count = 0;

   pal_bars_top i_dut (.clk(clk), .rst_n(rst_n), .mode(mode), .r(r), .g(g), .b(b),
                       .csync(csync));

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic line_kind_t expected_kind(input logic [9:0] vc, input logic prog);
      int v;
      v = int'(vc);
      if (v <= 1 || v == 313 || v == 314)
         return broad_broad;
      if (v == 2)
         return broad_eq;
      if (v == 312)
         return eq_broad;
      if (v == 3 || v == 4 || v == 310 || v == 311 || v == 315 || v == 316 || v >= 622)
         return eq_eq;
      if (prog && v == 309)
         return eq_eq;
      return normal;
   endfunction

   function automatic logic expected_csync(input logic [9:0] hc, input logic [9:0] vc,
                                           input logic prog);
      line_kind_t k;
      logic       upper;
      logic       broad;
      int         h;
      int         pos;
      k = expected_kind(vc, prog);
      h = int'(hc);
      upper = (h >= `PB_H_HALF);
      pos = upper ? h - `PB_H_HALF : h;
      broad = (k == broad_broad) || (k == broad_eq && !upper) || (k == eq_broad && upper);
      if (k == normal)
         return !(h < `PB_SYNC_LINE);
      return !(pos < (broad ? `PB_SYNC_BROAD : `PB_SYNC_EQ));
   endfunction

   function automatic rgb_t expected_rgb(input logic [9:0] hc, input logic [9:0] vc,
                                         input logic prog);
      rgb_t       c;
      int         bar;
      logic [2:0] bits;
      c = '0;
      if (expected_kind(vc, prog) == normal && int'(hc) >= `PB_ACTIVE_START) begin
         bar = (int'(hc) - `PB_ACTIVE_START) / `PB_BAR_WIDTH;
         bits = bar_table[(7 - bar) * 3 +: 3];
         c.r = {3{bits[2]}};
         c.g = {3{bits[1]}};
         c.b = {3{bits[0]}};
      end
      return c;
   endfunction

   // reference raster whose outputs lag the beam by one clock.
   always @(posedge clk) begin
      if (!rst_n) begin
         m_hc <= '0;
         m_vc <= '0;
         m_prog <= 1'b0;
         exp_csync <= 1'b1;
         exp_rgb <= '0;
      end
      else begin
         exp_csync <= expected_csync(m_hc, m_vc, m_prog);
         exp_rgb <= expected_rgb(m_hc, m_vc, m_prog);
         exp_hc <= m_hc;
         exp_vc <= m_vc;
         if (m_hc == 10'(`PB_H_TOTAL - 1)) begin
            m_hc <= '0;
            if (m_vc == (m_prog ? 10'(`PB_V_TOTAL_PROG - 1) : 10'(`PB_V_TOTAL_INT - 1))) begin
               m_vc <= '0;
               m_prog <= mode;
            end
            else begin
               m_vc <= m_vc + 10'd1;
            end
         end
         else begin
            m_hc <= m_hc + 10'd1;
         end
      end
   end

   always @(negedge clk) begin
      if (checking && (csync !== exp_csync || {r, g, b} !== exp_rgb)) begin
         $display("Mismatch at %0t: csync %b rgb %h, model csync %b rgb %h, line %0d pixel %0d",
                  $time, csync, {r, g, b}, exp_csync, exp_rgb, exp_vc, exp_hc);
         err_model = err_model + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("timeout: no end of test after %0d clock cycles", max_cycles);
         $display("sim failed");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
   endtask

   task automatic wait_frame_wrap();
      do begin
         @(posedge clk);
      end while (!(m_hc == 10'd0 && m_vc == 10'd0));
   endtask

   // counts falling csync edges over one whole line.
   task automatic count_sync_pulses(input logic [9:0] line, output int pulses);
      logic prev;
      while (!(m_vc == line && m_hc == 10'd0)) begin
         @(posedge clk);
      end
      prev = 1'b1;
      pulses = 0;
      repeat (`PB_H_TOTAL) begin
         @(negedge clk);
         if (prev && !csync)
            pulses++;
         prev = csync;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      int errs;
      errs = err_model + err_direct - errs_before;
      if (errs != 0)
         tests_failed++;
      $display("test %s: %0d errors", name, errs);
   endtask

   initial begin
      int          start;
      int          lows;
      int          pulses;
      int          left;
      int          changes;
      logic [15:0] bits;
      checking = 1'b0;
      rst_n <= 1'b0;
      mode <= 1'b0;
      @(posedge clk);
      checking = 1'b1;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // reset state and a broad first line.
      start = err_model + err_direct;
      @(negedge clk);
      if (csync !== 1'b1 || {r, g, b} !== 9'd0) begin
         $display("Mismatch at %0t: outputs not idle on the first clock after reset", $time);
         err_direct++;
      end
      lows = 0;
      repeat (`PB_H_TOTAL) begin
         @(negedge clk);
         if (!csync)
            lows++;
      end
      if (lows != 2 * `PB_SYNC_BROAD) begin
         $display("Mismatch at %0t: line 0 low for %0d clocks, expected %0d", $time, lows,
                  2 * `PB_SYNC_BROAD);
         err_direct++;
      end
      report_test("reset", start);

      // a mode raised mid-frame waits for the interlaced frame to wrap.
      start = err_model + err_direct;
      count_sync_pulses(10'd309, pulses);
      if (pulses != 1) begin
         $display("Mismatch at %0t: interlaced line 309 has %0d pulses", $time, pulses);
         err_direct++;
      end
      while (m_vc != 10'd400) begin
         @(posedge clk);
      end
      mode <= 1'b1;
      wait_frame_wrap();
      report_test("interlaced", start);

      start = err_model + err_direct;
      count_sync_pulses(10'd309, pulses);
      if (pulses != 2) begin
         $display("Mismatch at %0t: progressive line 309 has %0d pulses", $time, pulses);
         err_direct++;
      end
      wait_frame_wrap();
      wait_frame_wrap();
      report_test("progressive", start);

      // random mode levels at random gaps.
      start = err_model + err_direct;
      left = random_cycles;
      changes = 0;
      while (left > 0) begin
         take_bits(16, bits);
         repeat (int'(bits)) begin
            if (left > 0) begin
               @(posedge clk);
               left--;
            end
         end
         take_bits(1, bits);
         if (bits[0] != mode)
            changes++;
         mode <= bits[0];
      end
      if (changes == 0) begin
         $display("random stimulus never changed the mode level");
         err_direct++;
      end
      report_test("random", start);

      $display("tests run: 4, tests failing: %0d, model mismatches: %0d, direct errors: %0d",
               tests_failed, err_model, err_direct);
      if (err_model + err_direct == 0) begin
         $display("sim passed");
      end
      else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- dv/pal_bars_chk.sv
`timescale 1ns/1ps

module pal_bars_chk (
   input logic       clk,
   input logic       rst_n,
   input logic       csync,
   input logic [2:0] r,
   input logic [2:0] g,
   input logic [2:0] b
);

   // outputs sit idle through reset and on the clock after it.
   property idle_after_reset;
      @(posedge clk) !rst_n |=> (csync && {r, g, b} == 9'd0);
   endproperty

   // picture is black while a sync pulse is out.
   property black_in_sync;
      @(posedge clk) disable iff (!rst_n) !csync |-> ({r, g, b} == 9'd0);
   endproperty

   property outputs_known;
      @(posedge clk) disable iff (!rst_n) !$isunknown({csync, r, g, b});
   endproperty

   a_idle_after_reset: assert property (idle_after_reset)
      else $error("outputs not idle after reset");

   a_black_in_sync: assert property (black_in_sync)
      else $error("colour present during sync");

   a_outputs_known: assert property (outputs_known)
      else $error("unknown value on video outputs");

endmodule

bind pal_bars_top pal_bars_chk i_chk (
   .clk   (clk),
   .rst_n (rst_n),
   .csync (csync),
   .r     (r),
   .g     (g),
   .b     (b)
);

//--- verilog/pal_bars_top.sv
`timescale 1ns/1ps

module pal_bars_top
   import pal_bars_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       mode,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b,
   output logic       csync
);

   rgb_t pixel;

   raster_if rif ();

   // beam position and latched scan mode.
   raster_counter i_counter (
      .clk   (clk),
      .rst_n (rst_n),
      .mode  (mode),
      .rif   (rif.counter)
   );

   // composite sync and video enable.
   sync_decoder i_sync (
      .clk   (clk),
      .rst_n (rst_n),
      .rif   (rif.decoder),
      .csync (csync)
   );

   // colour bar painter.
   color_bars i_bars (
      .clk   (clk),
      .rst_n (rst_n),
      .rif   (rif.painter),
      .pixel (pixel)
   );

   assign r = pixel.r;
   assign g = pixel.g;
   assign b = pixel.b;

endmodule

//--- verilog/color_bars.sv
`timescale 1ns/1ps
`include "pal_bars_settings.svh"

module color_bars
   import pal_bars_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   raster_if.painter rif,
   output rgb_t      pixel
);

   localparam logic [9:0] active_start = 10'(`PB_ACTIVE_START);
   localparam int         num_bars     = 8;

   logic [9:0] offset;
   logic [2:0] bar_idx;

   // white, yellow, cyan, green, magenta, red, blue, black.
   // each bit switches a whole channel on.
   function automatic rgb_t bar_color(input logic [2:0] idx);
      logic [2:0] rgb_bits;
      rgb_t       c;
      case (idx)
         3'd0:    rgb_bits = 3'b111;
         3'd1:    rgb_bits = 3'b110;
         3'd2:    rgb_bits = 3'b011;
         3'd3:    rgb_bits = 3'b010;
         3'd4:    rgb_bits = 3'b101;
         3'd5:    rgb_bits = 3'b100;
         3'd6:    rgb_bits = 3'b001;
         default: rgb_bits = 3'b000;
      endcase
      c.r = {3{rgb_bits[2]}};
      c.g = {3{rgb_bits[1]}};
      c.b = {3{rgb_bits[0]}};
      return c;
   endfunction

   // pixel offset into the active part of the line.
   assign offset = rif.hc - active_start;

   // bar index by comparison against each bar boundary.
   always_comb begin
      bar_idx = 3'd0;
      for (int k = 1; k < num_bars; k++) begin
         if (offset >= 10'(k * `PB_BAR_WIDTH)) begin
            bar_idx = 3'(k);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pixel <= '0;
      end
      else if (rif.video_en) begin
         pixel <= bar_color(bar_idx);
      end
      else begin
         // blanking is black.
         pixel <= '0;
      end
   end

endmodule

//--- verilog/sync_decoder.sv
`timescale 1ns/1ps
`include "pal_bars_settings.svh"

module sync_decoder
   import pal_bars_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   raster_if.decoder rif,
   output logic      csync
);

   localparam logic [9:0] h_half       = 10'(`PB_H_HALF);
   localparam logic [9:0] sync_broad   = 10'(`PB_SYNC_BROAD);
   localparam logic [9:0] sync_eq      = 10'(`PB_SYNC_EQ);
   localparam logic [9:0] sync_line    = 10'(`PB_SYNC_LINE);
   localparam logic [9:0] active_start = 10'(`PB_ACTIVE_START);

   line_kind_t kind;
   logic       second_half;
   logic [9:0] half_pos;
   logic       csync_next;

   // pulse of one half-line, measured from the start of that half.
   function automatic logic half_low(input logic broad, input logic [9:0] pos);
      logic low;
      if (broad) begin
         low = (pos < sync_broad);
      end
      else begin
         low = (pos < sync_eq);
      end
      return low;
   endfunction

   // line classification.
   // lines 0 to 4 and 310 to 316 frame the two field boundaries,
   // 622 to 624 lead into the frame wrap.
   always_comb begin
      case (rif.vc)
         10'd0, 10'd1, 10'd313, 10'd314: begin
            kind = broad_broad;
         end
         10'd2: begin
            kind = broad_eq;
         end
         10'd312: begin
            kind = eq_broad;
         end
         10'd3, 10'd4, 10'd310, 10'd311, 10'd315, 10'd316,
         10'd622, 10'd623, 10'd624: begin
            kind = eq_eq;
         end
         10'd309: begin
            // progressive field needs one extra equalising line.
            kind = rif.progressive ? eq_eq : normal;
         end
         default: begin
            kind = normal;
         end
      endcase
   end

   // position within the current half-line.
   assign second_half = (rif.hc >= h_half);
   assign half_pos    = second_half ? (rif.hc - h_half) : rif.hc;

   always_comb begin
      case (kind)
         normal: begin
            csync_next = !(rif.hc < sync_line);
         end
         broad_broad: begin
            csync_next = !half_low(1'b1, half_pos);
         end
         broad_eq: begin
            csync_next = !half_low(!second_half, half_pos);
         end
         eq_broad: begin
            csync_next = !half_low(second_half, half_pos);
         end
         default: begin
            csync_next = !half_low(1'b0, half_pos);
         end
      endcase
   end

   // picture only on normal lines, after the back porch.
   assign rif.video_en = (kind == normal) && (rif.hc >= active_start);

   // registered so the output carries no decode glitches.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csync <= 1'b1;
      end
      else begin
         csync <= csync_next;
      end
   end

endmodule

//--- verilog/raster_counter.sv
`timescale 1ns/1ps
`include "pal_bars_settings.svh"

module raster_counter (
   input logic       clk,
   input logic       rst_n,
   input logic       mode,
   raster_if.counter rif
);

   localparam logic [9:0] h_last    = 10'(`PB_H_TOTAL - 1);
   localparam logic [9:0] v_last_in = 10'(`PB_V_TOTAL_INT - 1);
   localparam logic [9:0] v_last_pr = 10'(`PB_V_TOTAL_PROG - 1);

   logic       line_end;
   logic       frame_end;
   logic [9:0] v_last;

   // last line depends on the mode latched for this frame.
   assign v_last    = rif.progressive ? v_last_pr : v_last_in;
   assign line_end  = (rif.hc == h_last);
   assign frame_end = line_end && (rif.vc == v_last);

   // pixel counter.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rif.hc <= '0;
      end
      else if (line_end) begin
         rif.hc <= '0;
      end
      else begin
         rif.hc <= rif.hc + 10'd1;
      end
   end

   // line counter, steps once per line.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rif.vc <= '0;
      end
      else if (frame_end) begin
         rif.vc <= '0;
      end
      else if (line_end) begin
         rif.vc <= rif.vc + 10'd1;
      end
   end

   // mode is only taken at the frame wrap so a field is never cut short.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rif.progressive <= 1'b0;
      end
      else if (frame_end) begin
         rif.progressive <= mode;
      end
   end

endmodule

//--- verilog/raster_if.sv
`timescale 1ns/1ps

interface raster_if;

   // beam position.
   logic [9:0] hc;
   logic [9:0] vc;

   // scan mode of the frame in progress, 1 for progressive.
   logic       progressive;

   // high over the painted part of a normal line.
   logic       video_en;

   modport counter (
      output hc,
      output vc,
      output progressive
   );

   modport decoder (
      input  hc,
      input  vc,
      input  progressive,
      output video_en
   );

   modport painter (
      input  hc,
      input  video_en
   );

endinterface

//--- verilog/pal_bars_pkg.sv
package pal_bars_pkg;

   // one pixel, 3 bits per channel.
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } rgb_t;

   // sync pattern of a line, named as first half then second half.
   // a broad half is low for most of the half-line, an equalising half
   // only for a short pulse at its start.
   typedef enum logic [2:0] {
      normal      = 3'd0,
      broad_broad = 3'd1,
      broad_eq    = 3'd2,
      eq_broad    = 3'd3,
      eq_eq       = 3'd4
   } line_kind_t;

endpackage

//--- verilog/pal_bars_settings.svh
`ifndef PAL_BARS_SETTINGS_SVH
`define PAL_BARS_SETTINGS_SVH

// horizontal raster.
// one line is 64 us of 100 ns pixel clocks in this scaled model.
`define PB_H_TOTAL 640

// start of the second half-line, used by the vertical interval pulses.
`define PB_H_HALF 320

// vertical raster.
// interlaced frames carry two fields of 312.5 lines each.
`define PB_V_TOTAL_INT 625

// progressive frames repeat a single field without the half-line offset.
`define PB_V_TOTAL_PROG 312

// sync pulse widths in pixel clocks.
`define PB_SYNC_BROAD 300
`define PB_SYNC_EQ 20
`define PB_SYNC_LINE 40

// active video and bar geometry.
// eight bars of 65 pixels fill 120 to 639 exactly.
`define PB_ACTIVE_START 120
`define PB_BAR_WIDTH 65

`endif
